//--- Makefile
# Verilator flow for the SDP RAM testbench

VERILATOR ?= verilator
TOP       ?= mem_ram_sdp_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Result: FAILED
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A nonzero exit or the fail line in the log fails the target
run: $(SIM_BIN)
	@status=0; ./$(SIM_BIN) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ]; then \
		echo "Simulation exited with status $$status"; exit 1; \
	fi; \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure reported in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/mem_reset_fsm.sv
hdl/mem_ram_core.sv
hdl/mem_ram_sdp.sv
tests/mem_ram_sdp_sva.sv
tests/mem_ram_sdp_tb.sv

//--- hdl/mem_defs.svh
/*
 * Width, reset value and read latency macros for the SDP RAM
 */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ------------------------------
// Geometry
// ------------------------------

// Address width, gives 64 words
`define MEM_ADDR_WID 6

// Word width
`define MEM_DATA_WID 16

// ------------------------------
// Behaviour
// ------------------------------

// Written to every word by the init sequencer
`define MEM_RESET_VAL 16'h5a5a

// Accepted read request to read ack, in cycles
`define MEM_RD_LATENCY 2

`endif

//--- hdl/mem_pkg.sv
/*
 * Shared types for the SDP RAM
 * Field types plus request and response structs for both ports
 */
package mem_pkg;

`include "mem_defs.svh"

    // ------------------------------
    // Field types
    // ------------------------------
    typedef logic [`MEM_ADDR_WID-1:0] mem_addr_t;
    typedef logic [`MEM_DATA_WID-1:0] mem_data_t;

    // ------------------------------
    // Write port
    // ------------------------------

    // Request, 23 bits
    typedef struct packed {
        logic      req;
        mem_addr_t addr;
        mem_data_t data;
    } mem_wr_req_t;

    // Response, ack pulses one cycle after an accepted write
    typedef struct packed {
        logic rdy;
        logic ack;
    } mem_wr_resp_t;

    // ------------------------------
    // Read port
    // ------------------------------

    // Request, 7 bits
    typedef struct packed {
        logic      req;
        mem_addr_t addr;
    } mem_rd_req_t;

    // Response, data only meaningful with ack
    typedef struct packed {
        logic      rdy;
        logic      ack;
        mem_data_t data;
    } mem_rd_resp_t;

endpackage : mem_pkg

//--- hdl/mem_ram_core.sv
/*
 * Inferred SDP storage array with registered write ack
 * and a fixed-latency read-first read pipeline
 */
`timescale 1ns/1ps

`include "mem_defs.svh"

module mem_ram_core (
    input  logic                      mem_wr_if,
    input  logic                      rst,
    input  mem_pkg::mem_wr_req_t      wr,
    output logic                      wr_ack,
    input  mem_pkg::mem_rd_req_t      rd,
    output logic                      rd_ack,
    output logic [`MEM_DATA_WID-1:0]  rd_data
);
    import mem_pkg::*;

    localparam int DEPTH = 2 ** `MEM_ADDR_WID;
    localparam int LAT   = `MEM_RD_LATENCY;

    // ------------------------------
    // Signals
    // ------------------------------
    mem_data_t      mem_array [DEPTH];
    mem_data_t      rd_pipe   [LAT];
    logic [LAT-1:0] rd_vld;

    // ------------------------------
    // Storage
    // ------------------------------

    // Read-first: the read samples the word before
    // a write in the same cycle lands
    always_ff @(posedge mem_wr_if) begin
        if (wr.req) begin
            mem_array[wr.addr] <= wr.data;
        end
        if (rd.req) begin
            rd_pipe[0] <= mem_array[rd.addr];
        end
    end

    // ------------------------------
    // Read data pipeline
    // ------------------------------

    // Later stages shift every cycle, data is qualified by rd_vld
    always_ff @(posedge mem_wr_if) begin
        for (int i = 1; i < LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    // ------------------------------
    // Ack and valid
    // ------------------------------
    always_ff @(posedge mem_wr_if) begin
        if (rst) begin
            wr_ack <= 1'b0;
            rd_vld <= '0;
        end else begin
            wr_ack <= wr.req;
            rd_vld <= {rd_vld[LAT-2:0], rd.req};
        end
    end

    // Last stage drives the port
    assign rd_ack  = rd_vld[LAT-1];
    assign rd_data = rd_pipe[LAT-1];

endmodule : mem_ram_core

//--- hdl/mem_ram_sdp.sv
/*
 * SDP RAM top, init sequencer in front of the core write port
 * and read readiness gated by init completion
 */
`timescale 1ns/1ps

module mem_ram_sdp (
    input  logic                  mem_wr_if,
    input  logic                  rst,
    input  mem_pkg::mem_wr_req_t  wr_req,
    output mem_pkg::mem_wr_resp_t wr_resp,
    input  mem_pkg::mem_rd_req_t  rd_req,
    output mem_pkg::mem_rd_resp_t rd_resp
);
    import mem_pkg::*;

    // ------------------------------
    // Internal signals
    // ------------------------------
    mem_wr_req_t core_wr;
    logic        core_wr_ack;
    mem_rd_req_t core_rd;
    logic        core_rd_ack;
    mem_data_t   core_rd_data;
    logic        init_done;

    // ------------------------------
    // Init sequencer
    // ------------------------------
    mem_reset_fsm init_i (
        .mem_wr_if ( mem_wr_if   ),
        .rst       ( rst         ),
        .wr_in     ( wr_req      ),
        .core_ack  ( core_wr_ack ),
        .wr_out    ( core_wr     ),
        .wr_resp   ( wr_resp     ),
        .init_done ( init_done   )
    );

    // ------------------------------
    // Read request gating
    // ------------------------------

    // Reads are only accepted once init is done, so the core
    // never sees a request the user has to repeat
    always_comb begin
        core_rd.req  = rd_req.req && init_done;
        core_rd.addr = rd_req.addr;
    end

    // ------------------------------
    // Storage core
    // ------------------------------
    mem_ram_core core_i (
        .mem_wr_if ( mem_wr_if    ),
        .rst       ( rst          ),
        .wr        ( core_wr      ),
        .wr_ack    ( core_wr_ack  ),
        .rd        ( core_rd      ),
        .rd_ack    ( core_rd_ack  ),
        .rd_data   ( core_rd_data )
    );

    // ------------------------------
    // Read response
    // ------------------------------

    // Same clock on both ports, ready needs no synchronizer
    always_comb begin
        rd_resp.rdy  = init_done;
        rd_resp.ack  = core_rd_ack;
        rd_resp.data = core_rd_data;
    end

endmodule : mem_ram_sdp

//--- hdl/mem_reset_fsm.sv
/*
 * Init sequencer, clears every word after reset
 * and then forwards user writes to the RAM core
 */
`timescale 1ns/1ps

`include "mem_defs.svh"

module mem_reset_fsm (
    input  logic                  mem_wr_if,
    input  logic                  rst,
    input  mem_pkg::mem_wr_req_t  wr_in,
    input  logic                  core_ack,
    output mem_pkg::mem_wr_req_t  wr_out,
    output mem_pkg::mem_wr_resp_t wr_resp,
    output logic                  init_done
);
    import mem_pkg::*;

    localparam int DEPTH = 2 ** `MEM_ADDR_WID;

    // ------------------------------
    // State
    // ------------------------------
    typedef enum logic {
        ST_CLEAR = 1'b0,
        ST_DONE  = 1'b1
    } state_t;

    state_t    state;
    state_t    state_nxt;
    mem_addr_t clr_addr;
    logic      clr_arm;
    logic      clr_last;
    logic      user_wr_q;

    assign init_done = (state == ST_DONE);
    assign clr_last  = (clr_addr == mem_addr_t'(DEPTH - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_CLEAR: begin
                if (clr_arm && clr_last) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                // Held until the next reset
                state_nxt = ST_DONE;
            end
            default: begin
                state_nxt = ST_CLEAR;
            end
        endcase
    end

    // clr_arm rises at the first edge with rst low,
    // clear writes start in the cycle after it
    always_ff @(posedge mem_wr_if) begin
        if (rst) begin
            state     <= ST_CLEAR;
            clr_addr  <= '0;
            clr_arm   <= 1'b0;
            user_wr_q <= 1'b0;
        end else begin
            state     <= state_nxt;
            clr_arm   <= 1'b1;
            user_wr_q <= wr_in.req && init_done;
            if (clr_arm && (state == ST_CLEAR)) begin
                clr_addr <= clr_addr + 1'b1;
            end
        end
    end

    // ------------------------------
    // Write path mux
    // ------------------------------

    // User request is blocked until init is complete
    always_comb begin
        wr_out.req  = (wr_in.req && init_done) || (clr_arm && !init_done);
        wr_out.addr = init_done ? wr_in.addr : clr_addr;
        wr_out.data = init_done ? wr_in.data : mem_data_t'(`MEM_RESET_VAL);
    end

    // Core ack also fires for clear writes, so mask it
    // with the registered user write flag
    always_comb begin
        wr_resp.rdy = init_done;
        wr_resp.ack = core_ack && user_wr_q;
    end

endmodule : mem_reset_fsm

//--- tests/mem_ram_sdp_sva.sv
/*
 * Handshake and read latency assertions, bound into the SDP RAM top
 */
`timescale 1ns/1ps

`include "mem_defs.svh"

module mem_ram_sdp_sva (
    input logic                  mem_wr_if,
    input logic                  rst,
    input mem_pkg::mem_wr_req_t  wr_req,
    input mem_pkg::mem_wr_resp_t wr_resp,
    input mem_pkg::mem_rd_req_t  rd_req,
    input mem_pkg::mem_rd_resp_t rd_resp
);
    import mem_pkg::*;

    localparam int LAT = `MEM_RD_LATENCY;

    logic wr_acc;
    logic rd_acc;

    assign wr_acc = wr_req.req && wr_resp.rdy;
    assign rd_acc = rd_req.req && rd_resp.rdy;

    // ------------------------------
    // Handshake
    // ------------------------------
    a_no_ack_idle: assert property (@(posedge mem_wr_if) disable iff (rst)
        !(wr_resp.ack && !wr_resp.rdy) && !(rd_resp.ack && !rd_resp.rdy))
        else $error("ack seen while the port is not ready");

    // Write ack one cycle after acceptance, and only then
    a_wr_ack: assert property (@(posedge mem_wr_if) disable iff (rst)
        wr_acc |=> wr_resp.ack)
        else $error("write ack missing one cycle after an accepted write");

    a_wr_ack_src: assert property (@(posedge mem_wr_if) disable iff (rst)
        wr_resp.ack |-> $past(wr_acc))
        else $error("write ack without an accepted write");

    // ------------------------------
    // Read latency
    // ------------------------------
    a_rd_lat: assert property (@(posedge mem_wr_if) disable iff (rst)
        rd_acc |-> ##LAT rd_resp.ack)
        else $error("read ack missing after the fixed read latency");

    a_rd_ack_src: assert property (@(posedge mem_wr_if) disable iff (rst)
        rd_resp.ack |-> $past(rd_acc, LAT))
        else $error("read ack without a read accepted at the fixed latency");

endmodule : mem_ram_sdp_sva

bind mem_ram_sdp mem_ram_sdp_sva sva_i (
    .mem_wr_if ( mem_wr_if ),
    .rst       ( rst       ),
    .wr_req    ( wr_req    ),
    .wr_resp   ( wr_resp   ),
    .rd_req    ( rd_req    ),
    .rd_resp   ( rd_resp   )
);

//--- tests/mem_ram_sdp_tb.sv
/*
 * Testbench for the SDP RAM top, with a shadow memory model,
 * a table of write and read operations and a read pipeline check
 */
`timescale 1ns/1ps

`include "mem_defs.svh"

module mem_ram_sdp_tb;
    import mem_pkg::*;

    localparam int DEPTH        = 2 ** `MEM_ADDR_WID;
    localparam int LAT          = `MEM_RD_LATENCY;
    localparam int INIT_EDGES   = DEPTH + 1;
    localparam int INIT_TIMEOUT = DEPTH + 32;
    localparam int NUM_RANDOM   = 48;

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_WR,
        OP_RD,
        OP_WR_RD
    } op_t;

    typedef struct packed {
        op_t       op;
        mem_addr_t addr;
        mem_data_t data;
        mem_data_t exp;
    } entry_t;

    logic         mem_wr_if;
    logic         rst;
    mem_wr_req_t  wr_req;
    mem_wr_resp_t wr_resp;
    mem_rd_req_t  rd_req;
    mem_rd_resp_t rd_resp;

    // Shadow memory and expected responses
    mem_data_t shadow      [DEPTH];
    mem_data_t tbl_model   [DEPTH];
    entry_t    tbl         [$];
    logic      exp_rdy;
    logic      exp_wr_ack;
    logic      exp_rd_vld  [LAT];
    mem_addr_t exp_rd_addr [LAT];
    mem_data_t exp_rd_data [LAT];

    int check_cnt;
    int err_cnt;
    int timeout_cnt;

    mem_ram_sdp dut_i (
        .mem_wr_if ( mem_wr_if ),
        .rst       ( rst       ),
        .wr_req    ( wr_req    ),
        .wr_resp   ( wr_resp   ),
        .rd_req    ( rd_req    ),
        .rd_resp   ( rd_resp   )
    );

    always #10 mem_wr_if = ~mem_wr_if;

    // ------------------------------
    // Checks and cycle steps
    // ------------------------------
    task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR @ %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Outputs are sampled 1 ns after the edge, before new inputs
    task automatic sample_and_check();
        @(posedge mem_wr_if);
        #1;
        if (exp_rdy) begin
            check_val(32'(wr_resp.rdy), 1, "write ready held after init");
            check_val(32'(rd_resp.rdy), 1, "read ready held after init");
        end
        check_val(32'(wr_resp.ack), 32'(exp_wr_ack), "write ack");
        check_val(32'(rd_resp.ack), 32'(exp_rd_vld[LAT-1]), "read ack");
        if (exp_rd_vld[LAT-1]) begin
            check_val(32'(rd_resp.data), 32'(exp_rd_data[LAT-1]),
                      $sformatf("read data at address %0h", exp_rd_addr[LAT-1]));
        end
    endtask

    task automatic drive_ops(input logic do_wr, input mem_addr_t wa, input mem_data_t wd,
                             input logic do_rd, input mem_addr_t ra, input mem_data_t rd_exp);
        logic acc_wr;
        logic acc_rd;
        #1;
        wr_req.req  = do_wr;
        wr_req.addr = wa;
        wr_req.data = wd;
        rd_req.req  = do_rd;
        rd_req.addr = ra;
        // Both ports are ready from init completion until the next reset
        acc_wr = do_wr && exp_rdy;
        acc_rd = do_rd && exp_rdy;
        for (int i = LAT - 1; i > 0; i--) begin
            exp_rd_vld[i]  = exp_rd_vld[i-1];
            exp_rd_addr[i] = exp_rd_addr[i-1];
            exp_rd_data[i] = exp_rd_data[i-1];
        end
        exp_rd_vld[0]  = acc_rd;
        exp_rd_addr[0] = ra;
        exp_rd_data[0] = rd_exp;
        exp_wr_ack     = acc_wr;
        if (acc_wr) begin
            shadow[wa] = wd;
        end
    endtask

    task automatic run_cycle(input logic do_wr, input mem_addr_t wa, input mem_data_t wd,
                             input logic do_rd, input mem_addr_t ra, input mem_data_t rd_exp);
        sample_and_check();
        drive_ops(do_wr, wa, wd, do_rd, ra, rd_exp);
    endtask

    task automatic drain();
        repeat (LAT + 1) run_cycle(1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    // ------------------------------
    // Reset and init wait
    // ------------------------------
    task automatic apply_reset(input logic hold_wr, input mem_addr_t ha, input mem_data_t hd);
        int n;
        bit seen;
        rst        = 1'b1;
        wr_req     = '0;
        rd_req     = '0;
        exp_rdy    = 1'b0;
        exp_wr_ack = 1'b0;
        for (int i = 0; i < LAT; i++) begin
            exp_rd_vld[i] = 1'b0;
        end
        repeat (3) begin
            @(posedge mem_wr_if);
            #1;
            check_val(32'(wr_resp.rdy), 0, "write ready during reset");
            check_val(32'(rd_resp.rdy), 0, "read ready during reset");
            check_val(32'(wr_resp.ack), 0, "write ack during reset");
            check_val(32'(rd_resp.ack), 0, "read ack during reset");
            #1;
        end
        rst = 1'b0;
        // Held write, must stay out of the array during init
        if (hold_wr) begin
            wr_req.req  = 1'b1;
            wr_req.addr = ha;
            wr_req.data = hd;
        end
        foreach (shadow[a]) begin
            shadow[a] = mem_data_t'(`MEM_RESET_VAL);
        end
        n    = 0;
        seen = 1'b0;
        while (!seen && (n < INIT_TIMEOUT)) begin
            sample_and_check();
            n++;
            if (wr_resp.rdy || rd_resp.rdy) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            timeout_cnt++;
            $display("TIMEOUT: ready outputs did not rise within %0d cycles after reset release",
                     INIT_TIMEOUT);
        end else begin
            check_val(n, INIT_EDGES, "edges from reset release to ready");
            check_val(32'(wr_resp.rdy), 1, "write ready after init");
            check_val(32'(rd_resp.rdy), 1, "read ready after init");
            exp_rdy = 1'b1;
        end
        drive_ops(hold_wr, ha, hd, 1'b0, '0, '0);
    endtask

    task automatic read_sweep();
        for (int a = 0; a < DEPTH; a++) begin
            run_cycle(1'b0, '0, '0, 1'b1, mem_addr_t'(a), shadow[a]);
        end
        drain();
    endtask

    // ------------------------------
    // Operation table
    // ------------------------------
    function automatic void add_entry(input op_t op, input mem_addr_t addr, input mem_data_t data);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.data = data;
        // Read-first, so a read sees the word before this entry's write
        e.exp  = (op == OP_RD || op == OP_WR_RD) ? tbl_model[addr] : '0;
        if (op == OP_WR || op == OP_WR_RD) begin
            tbl_model[addr] = data;
        end
        tbl.push_back(e);
    endfunction

    function automatic void build_table();
        tbl.delete();
        foreach (shadow[a]) begin
            tbl_model[a] = shadow[a];
        end
        add_entry(OP_WR,    6'h05, 16'h1234);
        add_entry(OP_WR,    6'h3f, 16'hbeef);
        add_entry(OP_RD,    6'h05, 16'h0000);
        add_entry(OP_RD,    6'h3f, 16'h0000);
        add_entry(OP_RD,    6'h00, 16'h0000);
        add_entry(OP_WR_RD, 6'h05, 16'hcafe);
        add_entry(OP_RD,    6'h05, 16'h0000);
        add_entry(OP_WR,    6'h10, 16'h0001);
        add_entry(OP_WR,    6'h11, 16'h0002);
        add_entry(OP_RD,    6'h10, 16'h0000);
        add_entry(OP_RD,    6'h11, 16'h0000);
        add_entry(OP_IDLE,  6'h00, 16'h0000);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            add_entry(op_t'($urandom_range(3, 0)), mem_addr_t'($urandom()),
                      mem_data_t'($urandom()));
        end
    endfunction

    task automatic apply_table();
        entry_t e;
        logic   do_wr;
        logic   do_rd;
        foreach (tbl[i]) begin
            e     = tbl[i];
            do_wr = (e.op == OP_WR) || (e.op == OP_WR_RD);
            do_rd = (e.op == OP_RD) || (e.op == OP_WR_RD);
            run_cycle(do_wr, e.addr, e.data, do_rd, e.addr, e.exp);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(32'hbd20));
        mem_wr_if   = 1'b0;
        rst         = 1'b1;
        wr_req      = '0;
        rd_req      = '0;
        exp_rdy     = 1'b0;
        check_cnt   = 0;
        err_cnt     = 0;
        timeout_cnt = 0;

        apply_reset(1'b0, '0, '0);
        read_sweep();

        build_table();
        apply_table();
        drain();

        // Second reset after writes, every word cleared again
        apply_reset(1'b0, '0, '0);
        read_sweep();

        // Write held through init lands once ready is high
        apply_reset(1'b1, 6'h2a, 16'hc3a5);
        run_cycle(1'b0, '0, '0, 1'b0, '0, '0);
        run_cycle(1'b0, '0, '0, 1'b1, 6'h2a, shadow[6'h2a]);
        run_cycle(1'b0, '0, '0, 1'b1, 6'h29, shadow[6'h29]);
        drain();

        $display("Summary: %0d checks, %0d errors, %0d timeouts",
                 check_cnt, err_cnt, timeout_cnt);
        if ((err_cnt == 0) && (timeout_cnt == 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : mem_ram_sdp_tb
